// File: rtl/ctrl_pkg.sv
// Shared types, scan codes and bit positions of the player-control front end
package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Host key word: toggle at bit 10, pressed at bit 9, code in 7:0
  typedef logic [10:0] ps2_key_t;
  typedef logic [7:0]  scan_code_t;
  // One held flag per mapped key
  typedef logic [20:0] key_state_t;
  // Joystick word: directions, buttons, start, coin, pause, service
  typedef logic [10:0] joy_word_t;
  // Same order as joystick bits 0 to 9
  typedef logic [9:0]  player_ctrl_t;

  // Fields of the host key word
  localparam int PS2_TOGGLE_BIT  = 10;
  localparam int PS2_PRESSED_BIT = 9;

  //////////////////////////////////////////////////////////////////////
  // Key bit positions within key_state_t
  //////////////////////////////////////////////////////////////////////

  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_LEFT  = 2;
  localparam int KEY_RIGHT = 3;
  localparam int KEY_CTRL  = 4;
  localparam int KEY_ALT   = 5;
  localparam int KEY_SPACE = 6;
  localparam int KEY_1     = 7;
  localparam int KEY_2     = 8;
  localparam int KEY_5     = 9;
  localparam int KEY_6     = 10;
  localparam int KEY_9     = 11;
  localparam int KEY_0     = 12;
  localparam int KEY_A     = 13;
  localparam int KEY_S     = 14;
  localparam int KEY_Q     = 15;
  localparam int KEY_R     = 16;
  localparam int KEY_F     = 17;
  localparam int KEY_D     = 18;
  localparam int KEY_G     = 19;
  localparam int KEY_P     = 20;

  // Single-byte set 2 scan codes of the mapped keys
  localparam scan_code_t SC_UP    = 8'h75;
  localparam scan_code_t SC_DOWN  = 8'h72;
  localparam scan_code_t SC_LEFT  = 8'h6B;
  localparam scan_code_t SC_RIGHT = 8'h74;
  localparam scan_code_t SC_CTRL  = 8'h14;
  localparam scan_code_t SC_ALT   = 8'h11;
  localparam scan_code_t SC_SPACE = 8'h29;
  localparam scan_code_t SC_1     = 8'h16;
  localparam scan_code_t SC_2     = 8'h1E;
  localparam scan_code_t SC_5     = 8'h2E;
  localparam scan_code_t SC_6     = 8'h36;
  localparam scan_code_t SC_9     = 8'h46;
  localparam scan_code_t SC_0     = 8'h45;
  localparam scan_code_t SC_A     = 8'h1C;
  localparam scan_code_t SC_S     = 8'h1B;
  localparam scan_code_t SC_Q     = 8'h15;
  localparam scan_code_t SC_R     = 8'h2D;
  localparam scan_code_t SC_F     = 8'h2B;
  localparam scan_code_t SC_D     = 8'h23;
  localparam scan_code_t SC_G     = 8'h34;
  localparam scan_code_t SC_P     = 8'h4D;

  //////////////////////////////////////////////////////////////////////
  // Control bit positions within player_ctrl_t and joy_word_t
  //////////////////////////////////////////////////////////////////////

  localparam int CTRL_RIGHT = 0;
  localparam int CTRL_LEFT  = 1;
  localparam int CTRL_DOWN  = 2;
  localparam int CTRL_UP    = 3;
  localparam int CTRL_BTN1  = 4;
  localparam int CTRL_BTN2  = 5;
  localparam int CTRL_BTN3  = 6;
  localparam int CTRL_START = 7;
  localparam int CTRL_COIN  = 8;
  localparam int CTRL_PAUSE = 9;
  // Service exists only in the joystick word
  localparam int JOY_SERVICE = 10;

endpackage

// File: rtl/ps2_key_tracker.sv
// Key tracker that turns toggle-marked host key events into held key flags
`timescale 1ns/1ps

module ps2_key_tracker (
  input  logic                 clk_sys,
  input  logic                 RESET,
  input  ctrl_pkg::ps2_key_t   ps2_key,
  output ctrl_pkg::key_state_t key_state
);

  // Registered host word and the previous value of its toggle bit
  ctrl_pkg::ps2_key_t   key_q;
  logic                 toggle_q;

  // Decoded fields of the registered word
  logic                 key_event;
  logic                 pressed;
  ctrl_pkg::scan_code_t code;

  //////////////////////////////////////////////////////////////////////
  // Event detection
  //////////////////////////////////////////////////////////////////////

  // One sample of the host word, then a second copy of the toggle only
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      key_q    <= '0;
      toggle_q <= 1'b0;
    end else begin
      key_q    <= ps2_key;
      toggle_q <= key_q[ctrl_pkg::PS2_TOGGLE_BIT];
    end
  end

  // High for exactly one cycle per toggle flip
  assign key_event = key_q[ctrl_pkg::PS2_TOGGLE_BIT] != toggle_q;
  assign pressed   = key_q[ctrl_pkg::PS2_PRESSED_BIT];
  assign code      = key_q[7:0];

  //////////////////////////////////////////////////////////////////////
  // Held state per mapped key
  //////////////////////////////////////////////////////////////////////

  // Only the addressed flag moves, unknown codes are dropped
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      key_state <= '0;
    end else if (key_event) begin
      case (code)
        // Player 1 directions and buttons
        ctrl_pkg::SC_UP:    key_state[ctrl_pkg::KEY_UP]    <= pressed;
        ctrl_pkg::SC_DOWN:  key_state[ctrl_pkg::KEY_DOWN]  <= pressed;
        ctrl_pkg::SC_LEFT:  key_state[ctrl_pkg::KEY_LEFT]  <= pressed;
        ctrl_pkg::SC_RIGHT: key_state[ctrl_pkg::KEY_RIGHT] <= pressed;
        ctrl_pkg::SC_CTRL:  key_state[ctrl_pkg::KEY_CTRL]  <= pressed;
        ctrl_pkg::SC_ALT:   key_state[ctrl_pkg::KEY_ALT]   <= pressed;
        ctrl_pkg::SC_SPACE: key_state[ctrl_pkg::KEY_SPACE] <= pressed;
        // Start and coin keys of both players
        ctrl_pkg::SC_1:     key_state[ctrl_pkg::KEY_1]     <= pressed;
        ctrl_pkg::SC_2:     key_state[ctrl_pkg::KEY_2]     <= pressed;
        ctrl_pkg::SC_5:     key_state[ctrl_pkg::KEY_5]     <= pressed;
        ctrl_pkg::SC_6:     key_state[ctrl_pkg::KEY_6]     <= pressed;
        // Service keys
        ctrl_pkg::SC_9:     key_state[ctrl_pkg::KEY_9]     <= pressed;
        ctrl_pkg::SC_0:     key_state[ctrl_pkg::KEY_0]     <= pressed;
        // Player 2 buttons
        ctrl_pkg::SC_A:     key_state[ctrl_pkg::KEY_A]     <= pressed;
        ctrl_pkg::SC_S:     key_state[ctrl_pkg::KEY_S]     <= pressed;
        ctrl_pkg::SC_Q:     key_state[ctrl_pkg::KEY_Q]     <= pressed;
        // Player 2 directions on the RFDG cluster
        ctrl_pkg::SC_R:     key_state[ctrl_pkg::KEY_R]     <= pressed;
        ctrl_pkg::SC_F:     key_state[ctrl_pkg::KEY_F]     <= pressed;
        ctrl_pkg::SC_D:     key_state[ctrl_pkg::KEY_D]     <= pressed;
        ctrl_pkg::SC_G:     key_state[ctrl_pkg::KEY_G]     <= pressed;
        // Pause for player 1 only
        ctrl_pkg::SC_P:     key_state[ctrl_pkg::KEY_P]     <= pressed;
        default: begin
          key_state <= key_state;
        end
      endcase
    end
  end

endmodule

// File: rtl/joy_port_receiver.sv
// Four-phase req/ack receiver holding the latest joystick word of each player
`timescale 1ns/1ps

module joy_port_receiver #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk_sys,
  input  logic                RESET,
  input  logic                joy_req,
  input  logic                joy_sel,
  input  ctrl_pkg::joy_word_t joy_word,
  output logic                joy_ack,
  output ctrl_pkg::joy_word_t joy_p1,
  output ctrl_pkg::joy_word_t joy_p2
);

  // RX_ACK is the latch cycle, RX_WAIT_LOW holds ack until req drops
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_ACK,
    RX_WAIT_LOW
  } rx_state_t;

  rx_state_t              state;
  logic [SYNC_STAGES-1:0] req_sync;
  logic                   req_s;
  logic                   take;

  //////////////////////////////////////////////////////////////////////
  // Request synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      req_sync <= '0;
    end else begin
      req_sync <= {req_sync[SYNC_STAGES-2:0], joy_req};
    end
  end

  assign req_s = req_sync[SYNC_STAGES-1];

  // New request seen, word and select are already stable
  assign take = (state == RX_IDLE) && req_s;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      state   <= RX_IDLE;
      joy_ack <= 1'b0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (take) begin
            state   <= RX_ACK;
            joy_ack <= 1'b1;
          end
        end
        RX_ACK: begin
          state <= RX_WAIT_LOW;
        end
        RX_WAIT_LOW: begin
          // A held req stays here and is never taken twice
          if (!req_s) begin
            state   <= RX_IDLE;
            joy_ack <= 1'b0;
          end
        end
        default: begin
          state   <= RX_IDLE;
          joy_ack <= 1'b0;
        end
      endcase
    end
  end

  // Word registers, loaded on the same edge as the ack rise
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      joy_p1 <= '0;
      joy_p2 <= '0;
    end else if (take) begin
      if (joy_sel) begin
        joy_p2 <= joy_word;
      end else begin
        joy_p1 <= joy_word;
      end
    end
  end

endmodule

// File: rtl/control_combiner.sv
// Merges held keys and joystick words into registered player and service lines
`timescale 1ns/1ps

module control_combiner (
  input  logic                   clk_sys,
  input  logic                   RESET,
  input  ctrl_pkg::key_state_t   key_state,
  input  ctrl_pkg::joy_word_t    joy_p1,
  input  ctrl_pkg::joy_word_t    joy_p2,
  output ctrl_pkg::player_ctrl_t p1_ctrl,
  output ctrl_pkg::player_ctrl_t p2_ctrl,
  output logic [1:0]             svc
);

  // Key contributions laid out in control bit order
  ctrl_pkg::player_ctrl_t p1_keys;
  ctrl_pkg::player_ctrl_t p2_keys;

  //////////////////////////////////////////////////////////////////////
  // Key to control mapping
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    p1_keys = '0;
    // Arrows, CTRL/ALT/SPACE, 1 and 5, P
    p1_keys[ctrl_pkg::CTRL_RIGHT] = key_state[ctrl_pkg::KEY_RIGHT];
    p1_keys[ctrl_pkg::CTRL_LEFT]  = key_state[ctrl_pkg::KEY_LEFT];
    p1_keys[ctrl_pkg::CTRL_DOWN]  = key_state[ctrl_pkg::KEY_DOWN];
    p1_keys[ctrl_pkg::CTRL_UP]    = key_state[ctrl_pkg::KEY_UP];
    p1_keys[ctrl_pkg::CTRL_BTN1]  = key_state[ctrl_pkg::KEY_CTRL];
    p1_keys[ctrl_pkg::CTRL_BTN2]  = key_state[ctrl_pkg::KEY_ALT];
    p1_keys[ctrl_pkg::CTRL_BTN3]  = key_state[ctrl_pkg::KEY_SPACE];
    p1_keys[ctrl_pkg::CTRL_START] = key_state[ctrl_pkg::KEY_1];
    p1_keys[ctrl_pkg::CTRL_COIN]  = key_state[ctrl_pkg::KEY_5];
    p1_keys[ctrl_pkg::CTRL_PAUSE] = key_state[ctrl_pkg::KEY_P];
  end

  always_comb begin
    // Pause bit stays zero, player 2 pause is joystick only
    p2_keys = '0;
    p2_keys[ctrl_pkg::CTRL_RIGHT] = key_state[ctrl_pkg::KEY_G];
    p2_keys[ctrl_pkg::CTRL_LEFT]  = key_state[ctrl_pkg::KEY_D];
    p2_keys[ctrl_pkg::CTRL_DOWN]  = key_state[ctrl_pkg::KEY_F];
    p2_keys[ctrl_pkg::CTRL_UP]    = key_state[ctrl_pkg::KEY_R];
    p2_keys[ctrl_pkg::CTRL_BTN1]  = key_state[ctrl_pkg::KEY_A];
    p2_keys[ctrl_pkg::CTRL_BTN2]  = key_state[ctrl_pkg::KEY_S];
    p2_keys[ctrl_pkg::CTRL_BTN3]  = key_state[ctrl_pkg::KEY_Q];
    p2_keys[ctrl_pkg::CTRL_START] = key_state[ctrl_pkg::KEY_2];
    p2_keys[ctrl_pkg::CTRL_COIN]  = key_state[ctrl_pkg::KEY_6];
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      p1_ctrl <= '0;
      p2_ctrl <= '0;
      svc     <= 2'b00;
    end else begin
      // Either source holds a bit high
      p1_ctrl <= p1_keys | joy_p1[ctrl_pkg::CTRL_PAUSE:ctrl_pkg::CTRL_RIGHT];
      p2_ctrl <= p2_keys | joy_p2[ctrl_pkg::CTRL_PAUSE:ctrl_pkg::CTRL_RIGHT];
      // Bit 0 key 9 with player 1 service, bit 1 key 0 with player 2
      svc[0]  <= key_state[ctrl_pkg::KEY_9] | joy_p1[ctrl_pkg::JOY_SERVICE];
      svc[1]  <= key_state[ctrl_pkg::KEY_0] | joy_p2[ctrl_pkg::JOY_SERVICE];
    end
  end

endmodule

// File: rtl/ctrl_front_end.sv
// Player-control front end joining key tracker, joystick port and combiner
`timescale 1ns/1ps

module ctrl_front_end #(
  // Flops on joy_req before the handshake FSM, 2 or more
  parameter int SYNC_STAGES = 2
) (
  input  logic                   clk_sys,
  input  logic                   RESET,
  // Host key word, one event per flip of bit 10
  input  ctrl_pkg::ps2_key_t     ps2_key,
  // Joystick port, four-phase handshake
  input  logic                   joy_req,
  input  logic                   joy_sel,
  input  ctrl_pkg::joy_word_t    joy_word,
  output logic                   joy_ack,
  // Merged controls toward the game core
  output ctrl_pkg::player_ctrl_t p1_ctrl,
  output ctrl_pkg::player_ctrl_t p2_ctrl,
  output logic [1:0]             svc
);

  ctrl_pkg::key_state_t key_state;
  ctrl_pkg::joy_word_t  joy_p1;
  ctrl_pkg::joy_word_t  joy_p2;

  //////////////////////////////////////////////////////////////////////
  // Input sources
  //////////////////////////////////////////////////////////////////////

  // Two cycles from a key word change to key_state
  ps2_key_tracker u_ps2_key_tracker (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .ps2_key   (ps2_key),
    .key_state (key_state)
  );

  joy_port_receiver #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_joy_port_receiver (
    .clk_sys  (clk_sys),
    .RESET    (RESET),
    .joy_req  (joy_req),
    .joy_sel  (joy_sel),
    .joy_word (joy_word),
    .joy_ack  (joy_ack),
    .joy_p1   (joy_p1),
    .joy_p2   (joy_p2)
  );

  //////////////////////////////////////////////////////////////////////
  // Merge stage
  //////////////////////////////////////////////////////////////////////

  // One more register, so keys show after 3 cycles and joysticks 1 after ack
  control_combiner u_control_combiner (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .key_state (key_state),
    .joy_p1    (joy_p1),
    .joy_p2    (joy_p2),
    .p1_ctrl   (p1_ctrl),
    .p2_ctrl   (p2_ctrl),
    .svc       (svc)
  );

endmodule

// File: test/ctrl_ref_model.svh
// Reference model of held keys and joystick words with the expected merged controls
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// Held flag for every scan code, unmapped ones never reach an output
logic model_key [0:255];
// Last word latched for each player
ctrl_pkg::joy_word_t model_joy1;
ctrl_pkg::joy_word_t model_joy2;

// Everything released, both joystick words zero, as after reset
task automatic clear_model();
  for (int i = 0; i < 256; i++) begin
    model_key[i] = 1'b0;
  end
  model_joy1 = '0;
  model_joy2 = '0;
endtask

// Each control bit is its key OR the same joystick bit
function automatic void expect_ctrl(output ctrl_pkg::player_ctrl_t p1,
                                    output ctrl_pkg::player_ctrl_t p2,
                                    output logic [1:0] s);
  p1 = model_joy1[9:0];
  p2 = model_joy2[9:0];
  // Player 1 on arrows, CTRL/ALT/SPACE, 1, 5 and P
  p1[ctrl_pkg::CTRL_RIGHT] |= model_key[ctrl_pkg::SC_RIGHT];
  p1[ctrl_pkg::CTRL_LEFT]  |= model_key[ctrl_pkg::SC_LEFT];
  p1[ctrl_pkg::CTRL_DOWN]  |= model_key[ctrl_pkg::SC_DOWN];
  p1[ctrl_pkg::CTRL_UP]    |= model_key[ctrl_pkg::SC_UP];
  p1[ctrl_pkg::CTRL_BTN1]  |= model_key[ctrl_pkg::SC_CTRL];
  p1[ctrl_pkg::CTRL_BTN2]  |= model_key[ctrl_pkg::SC_ALT];
  p1[ctrl_pkg::CTRL_BTN3]  |= model_key[ctrl_pkg::SC_SPACE];
  p1[ctrl_pkg::CTRL_START] |= model_key[ctrl_pkg::SC_1];
  p1[ctrl_pkg::CTRL_COIN]  |= model_key[ctrl_pkg::SC_5];
  p1[ctrl_pkg::CTRL_PAUSE] |= model_key[ctrl_pkg::SC_P];
  // Player 2 on RFDG, A/S/Q, 2 and 6, no pause key
  p2[ctrl_pkg::CTRL_RIGHT] |= model_key[ctrl_pkg::SC_G];
  p2[ctrl_pkg::CTRL_LEFT]  |= model_key[ctrl_pkg::SC_D];
  p2[ctrl_pkg::CTRL_DOWN]  |= model_key[ctrl_pkg::SC_F];
  p2[ctrl_pkg::CTRL_UP]    |= model_key[ctrl_pkg::SC_R];
  p2[ctrl_pkg::CTRL_BTN1]  |= model_key[ctrl_pkg::SC_A];
  p2[ctrl_pkg::CTRL_BTN2]  |= model_key[ctrl_pkg::SC_S];
  p2[ctrl_pkg::CTRL_BTN3]  |= model_key[ctrl_pkg::SC_Q];
  p2[ctrl_pkg::CTRL_START] |= model_key[ctrl_pkg::SC_2];
  p2[ctrl_pkg::CTRL_COIN]  |= model_key[ctrl_pkg::SC_6];
  s[0] = model_key[ctrl_pkg::SC_9] | model_joy1[ctrl_pkg::JOY_SERVICE];
  s[1] = model_key[ctrl_pkg::SC_0] | model_joy2[ctrl_pkg::JOY_SERVICE];
endfunction

`endif

// File: test/tb_ctrl_front_end.sv
// Testbench for the player-control front end covering keys, joystick port and merging
`timescale 1ns/1ps

module tb_ctrl_front_end;

  localparam int ACK_TIMEOUT = 40;

  logic                   clk_sys = 1'b0;
  logic                   RESET;
  ctrl_pkg::ps2_key_t     ps2_key;
  logic                   joy_req;
  logic                   joy_sel;
  ctrl_pkg::joy_word_t    joy_word;
  logic                   joy_ack;
  ctrl_pkg::player_ctrl_t p1_ctrl;
  ctrl_pkg::player_ctrl_t p2_ctrl;
  logic [1:0]             svc;

  int                   errors = 0;
  int                   seed = 4;
  logic                 key_toggle;
  string                test_name;
  event                 check_now;
  ctrl_pkg::scan_code_t key_codes [21];

  `include "ctrl_ref_model.svh"

  ctrl_front_end #(
    .SYNC_STAGES (2)
  ) u_ctrl_front_end (
    .clk_sys  (clk_sys),
    .RESET    (RESET),
    .ps2_key  (ps2_key),
    .joy_req  (joy_req),
    .joy_sel  (joy_sel),
    .joy_word (joy_word),
    .joy_ack  (joy_ack),
    .p1_ctrl  (p1_ctrl),
    .p2_ctrl  (p2_ctrl),
    .svc      (svc)
  );

  // 4 ns period
  always #2 clk_sys = ~clk_sys;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and compare process
  //////////////////////////////////////////////////////////////////////

  task automatic check_ctrl(input string name, input ctrl_pkg::player_ctrl_t expected,
                            input ctrl_pkg::player_ctrl_t actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_svc(input string name, input logic [1:0] expected,
                           input logic [1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_ack(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Runs at a falling edge, outputs are settled there
  always @(check_now) begin : compare_outputs
    ctrl_pkg::player_ctrl_t exp_p1;
    ctrl_pkg::player_ctrl_t exp_p2;
    logic [1:0]             exp_svc;
    expect_ctrl(exp_p1, exp_p2, exp_svc);
    check_ctrl({test_name, " p1_ctrl"}, exp_p1, p1_ctrl);
    check_ctrl({test_name, " p2_ctrl"}, exp_p2, p2_ctrl);
    check_svc({test_name, " svc"}, exp_svc, svc);
  end

  // Model is left alone until the next rising edge
  task automatic check_outputs(input string name);
    test_name = name;
    -> check_now;
    @(posedge clk_sys);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Without flip the word is rewritten with the old toggle, no event
  task automatic send_key(input string name, input ctrl_pkg::scan_code_t code,
                          input logic pressed, input logic flip);
    @(negedge clk_sys);
    if (flip) begin
      key_toggle = ~key_toggle;
      model_key[code] = pressed;
    end
    ps2_key = {key_toggle, pressed, 1'b0, code};
    // Outputs follow 3 cycles later, checked after 4
    repeat (4) @(negedge clk_sys);
    check_outputs(name);
  endtask

  task automatic send_joy(input string name, input logic sel,
                          input ctrl_pkg::joy_word_t word);
    int n;
    @(negedge clk_sys);
    check_ack({name, " ack idle"}, 1'b0, joy_ack);
    joy_sel  = sel;
    joy_word = word;
    joy_req  = 1'b1;
    n = 0;
    while (!joy_ack && n < ACK_TIMEOUT) begin
      @(negedge clk_sys);
      n++;
    end
    if (!joy_ack) begin
      errors++;
      $display("%s: joy_ack did not rise within %0d cycles of joy_req", name, ACK_TIMEOUT);
    end
    if (sel) begin
      model_joy2 = word;
    end else begin
      model_joy1 = word;
    end
    repeat (2) @(negedge clk_sys);
    check_outputs(name);
    // Req still high, so ack has to stay up
    @(negedge clk_sys);
    check_ack({name, " ack held"}, 1'b1, joy_ack);
    joy_req = 1'b0;
    n = 0;
    while (joy_ack && n < ACK_TIMEOUT) begin
      @(negedge clk_sys);
      n++;
    end
    if (joy_ack) begin
      errors++;
      $display("%s: joy_ack did not fall within %0d cycles of req low", name, ACK_TIMEOUT);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                   r;
    int                   idx;
    ctrl_pkg::scan_code_t code;
    RESET      = 1'b1;
    ps2_key    = '0;
    joy_req    = 1'b0;
    joy_sel    = 1'b0;
    joy_word   = '0;
    key_toggle = 1'b0;
    key_codes  = '{ctrl_pkg::SC_UP, ctrl_pkg::SC_DOWN, ctrl_pkg::SC_LEFT, ctrl_pkg::SC_RIGHT,
                   ctrl_pkg::SC_CTRL, ctrl_pkg::SC_ALT, ctrl_pkg::SC_SPACE, ctrl_pkg::SC_1,
                   ctrl_pkg::SC_2, ctrl_pkg::SC_5, ctrl_pkg::SC_6, ctrl_pkg::SC_9,
                   ctrl_pkg::SC_0, ctrl_pkg::SC_A, ctrl_pkg::SC_S, ctrl_pkg::SC_Q,
                   ctrl_pkg::SC_R, ctrl_pkg::SC_F, ctrl_pkg::SC_D, ctrl_pkg::SC_G,
                   ctrl_pkg::SC_P};
    clear_model();
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    RESET = 1'b0;

    // Reset values
    check_ack("reset joy_ack", 1'b0, joy_ack);
    check_outputs("reset");

    // Every mapped key pressed and released
    foreach (key_codes[i]) begin
      send_key($sformatf("key %h press", key_codes[i]), key_codes[i], 1'b1, 1'b1);
      send_key($sformatf("key %h release", key_codes[i]), key_codes[i], 1'b0, 1'b1);
    end
    // Unknown code and a repeated toggle while up is held
    send_key("hold up", ctrl_pkg::SC_UP, 1'b1, 1'b1);
    send_key("unmapped code", 8'h5A, 1'b1, 1'b1);
    send_key("same toggle", ctrl_pkg::SC_UP, 1'b0, 1'b0);
    send_key("release up", ctrl_pkg::SC_UP, 1'b0, 1'b1);

    // Transfers to each player
    send_joy("joy p1", 1'b0, 11'h2A5);
    send_joy("joy p2", 1'b1, 11'h15A);
    send_joy("joy p1 clear", 1'b0, '0);
    send_joy("joy p2 clear", 1'b1, '0);

    // Key and joystick button 1 together
    send_key("merge key", ctrl_pkg::SC_CTRL, 1'b1, 1'b1);
    send_joy("merge joy", 1'b0, 11'h010);
    send_key("merge key up", ctrl_pkg::SC_CTRL, 1'b0, 1'b1);
    send_joy("merge joy up", 1'b0, '0);
    // P reaches player 1 only and player 2 pause follows its joystick
    send_joy("p2 pause joy", 1'b1, 11'h200);
    send_key("pause key", ctrl_pkg::SC_P, 1'b1, 1'b1);
    send_joy("p2 pause clear", 1'b1, '0);
    send_key("pause key up", ctrl_pkg::SC_P, 1'b0, 1'b1);
    // Service lines from keys 9 and 0 and joystick bit 10
    send_key("svc key 9", ctrl_pkg::SC_9, 1'b1, 1'b1);
    send_joy("svc joy p1", 1'b0, 11'h400);
    send_joy("svc joy p2", 1'b1, 11'h400);
    send_key("svc key 0", ctrl_pkg::SC_0, 1'b1, 1'b1);
    send_key("svc key 9 up", ctrl_pkg::SC_9, 1'b0, 1'b1);
    send_joy("svc joy p1 clear", 1'b0, '0);

    // Mixed random steps with mostly mapped codes
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      if (r[0]) begin
        idx  = int'(r[31:16]) % 21;
        code = (r[3:1] == 3'd0) ? r[15:8] : key_codes[idx];
        send_key($sformatf("random %0d key", i), code, r[4], 1'b1);
      end else begin
        send_joy($sformatf("random %0d joy", i), r[5], r[26:16]);
      end
    end

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+test
rtl/ctrl_pkg.sv
rtl/ps2_key_tracker.sv
rtl/joy_port_receiver.sv
rtl/control_combiner.sv
rtl/ctrl_front_end.sv
test/tb_ctrl_front_end.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the front-end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_ctrl_front_end --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ctrl_front_end > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi
